// File: include/axi_ctrl_settings.svh
/* Widths, counts, FIFO depth and region base addresses of the AXI peripheral controller.
   Included by the package and by every module that sizes ports or decodes addresses. */
`ifndef AXI_CTRL_SETTINGS_SVH
`define AXI_CTRL_SETTINGS_SVH

// Bus widths
`define AXC_DATA_W      8
`define AXC_ADDR_W      32

// Region sizes
`define AXC_CONF_NUM    8
`define AXC_STAT_NUM    8
`define AXC_TX_NUM      2
`define AXC_RX_NUM      2
`define AXC_FIFO_DEPTH  4           // Entries per stream FIFO

// Base addresses, one byte per register
`define AXC_CONF_BASE   32'h2000_0000
`define AXC_TX_BASE     32'h2100_0000
`define AXC_RX_BASE     32'h2200_0000
`define AXC_STAT_BASE   32'h2400_0000

`endif

// File: logic/axi_ctrl_pkg.sv
/* Shared types of the AXI peripheral controller, compiled before every other design file */
`default_nettype none

`include "axi_ctrl_settings.svh"

package axi_ctrl_pkg;

    typedef logic [`AXC_DATA_W-1:0]                 data_t;       // Register or stream byte
    typedef logic [`AXC_ADDR_W-1:0]                 addr_t;
    typedef logic [$clog2(`AXC_FIFO_DEPTH+1)-1:0]   cnt_t;        // 0 to depth
    typedef logic [$clog2(`AXC_CONF_NUM)-1:0]       conf_idx_t;
    typedef logic [$clog2(`AXC_TX_NUM)-1:0]         stream_idx_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11                                       // Wrong mapping
    } resp_e;

    typedef enum logic [2:0] {REG_NONE, REG_CONF, REG_STAT, REG_TX, REG_RX} region_e;

endpackage

`default_nettype wire

// File: logic/axi_ctrl_if.sv
/* Internal links of the controller: the host bus from the AXI frontend to the
   register map, and the register map's ports to the transmit and receive streams */
`timescale 1ns/1ps
`default_nettype none

interface host_bus_if;
    import axi_ctrl_pkg::*;

    logic   wr_req;             // Joined AW and W request
    addr_t  wr_addr;
    data_t  wr_data;
    logic   wr_ready;           // Low only while a TX FIFO is full
    logic   wr_ok;
    logic   rd_req;
    addr_t  rd_addr;
    logic   rd_ready;           // Low only while an RX FIFO is empty
    logic   rd_ok;
    data_t  rd_data;

    modport host   (output wr_req, wr_addr, wr_data, rd_req, rd_addr,
                    input  wr_ready, wr_ok, rd_ready, rd_ok, rd_data);
    modport target (input  wr_req, wr_addr, wr_data, rd_req, rd_addr,
                    output wr_ready, wr_ok, rd_ready, rd_ok, rd_data);
endinterface

interface tx_port_if;
    import axi_ctrl_pkg::*;

    logic        push_en;
    stream_idx_t push_idx;
    data_t       push_data;
    logic        push_ready;    // Selected FIFO not full
    stream_idx_t cnt_idx;
    cnt_t        count;         // Occupancy of FIFO at cnt_idx

    modport master (output push_en, push_idx, push_data, cnt_idx, input push_ready, count);
    modport slave  (input push_en, push_idx, push_data, cnt_idx, output push_ready, count);
endinterface

interface rx_port_if;
    import axi_ctrl_pkg::*;

    logic        pop_en;
    stream_idx_t pop_idx;
    logic        pop_ready;     // Selected FIFO not empty
    data_t       pop_data;      // Head of selected FIFO

    modport master (output pop_en, pop_idx, input pop_ready, pop_data);
    modport slave  (input pop_en, pop_idx, output pop_ready, pop_data);
endinterface

`default_nettype wire

// File: logic/axi_lite_frontend.sv
/* AXI4-Lite slave handshakes. Joins AW and W into one host write, passes AR on as a
   host read, and registers the B and R responses until the master takes them */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_frontend (
    input  logic                clk,
    input  logic                rst_n,
    // AW channel
    input  axi_ctrl_pkg::addr_t s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    // W channel
    input  axi_ctrl_pkg::data_t s_wdata_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    // B channel
    output axi_ctrl_pkg::resp_e s_bresp_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    // AR channel
    input  axi_ctrl_pkg::addr_t s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    // R channel
    output axi_ctrl_pkg::data_t s_rdata_o,
    output axi_ctrl_pkg::resp_e s_rresp_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    host_bus_if.host            bus_o
);
    import axi_ctrl_pkg::*;

    logic wr_hsk;   // Write accepted this cycle
    logic rd_hsk;   // Read accepted this cycle

    // Write request only with both channels present and B slot free
    assign bus_o.wr_req  = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
    assign bus_o.wr_addr = s_awaddr_i;
    assign bus_o.wr_data = s_wdata_i;
    assign wr_hsk        = bus_o.wr_req & bus_o.wr_ready;
    assign s_awready_o   = wr_hsk;              // AW and W taken together
    assign s_wready_o    = wr_hsk;

    assign bus_o.rd_req  = s_arvalid_i & ~s_rvalid_o;   // Blocked while R pending
    assign bus_o.rd_addr = s_araddr_i;
    assign rd_hsk        = bus_o.rd_req & bus_o.rd_ready;
    assign s_arready_o   = rd_hsk;

    // B valid, held until bready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_bvalid_o <= 1'b0;
        end else if (wr_hsk) begin
            s_bvalid_o <= 1'b1;
        end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
        end
    end

    // R valid, same scheme
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid_o <= 1'b0;
        end else if (rd_hsk) begin
            s_rvalid_o <= 1'b1;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    // Response payload, loaded on the handshake edge only
    always_ff @(posedge clk) begin
        if (wr_hsk) begin
            s_bresp_o <= bus_o.wr_ok ? RESP_OKAY : RESP_DECERR;
        end
        if (rd_hsk) begin
            s_rresp_o <= bus_o.rd_ok ? RESP_OKAY : RESP_DECERR;
            s_rdata_o <= bus_o.rd_data;         // Zero on a refused read
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_map.sv
/* Address decode and register map. Holds the configuration registers, muxes status
   reads, and routes TX writes and RX reads to the stream blocks */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module reg_map (
    input  logic                clk,
    input  logic                rst_n,
    host_bus_if.target          bus_i,
    input  axi_ctrl_pkg::data_t stat_reg_i [`AXC_STAT_NUM],
    output axi_ctrl_pkg::data_t conf_reg_o [`AXC_CONF_NUM],
    tx_port_if.master           tx_o,
    rx_port_if.master           rx_o
);
    import axi_ctrl_pkg::*;

    region_e     wr_region;
    region_e     rd_region;
    conf_idx_t   wr_idx;
    conf_idx_t   rd_idx;

    // Exact hit on base plus index, index below the region size
    function automatic region_e decode_region(input addr_t addr);
        region_e region;
        region = REG_NONE;
        if ((addr - addr_t'(`AXC_CONF_BASE)) < `AXC_CONF_NUM) begin
            region = REG_CONF;
        end else if ((addr - addr_t'(`AXC_STAT_BASE)) < `AXC_STAT_NUM) begin
            region = REG_STAT;
        end else if ((addr - addr_t'(`AXC_TX_BASE)) < `AXC_TX_NUM) begin
            region = REG_TX;
        end else if ((addr - addr_t'(`AXC_RX_BASE)) < `AXC_RX_NUM) begin
            region = REG_RX;
        end
        return region;
    endfunction

    assign wr_region = decode_region(bus_i.wr_addr);
    assign rd_region = decode_region(bus_i.rd_addr);
    assign wr_idx    = conf_idx_t'(bus_i.wr_addr);    // Bases are aligned, low bits give index
    assign rd_idx    = conf_idx_t'(bus_i.rd_addr);

    // Stream peers
    assign tx_o.push_en   = bus_i.wr_req & (wr_region == REG_TX);
    assign tx_o.push_idx  = stream_idx_t'(wr_idx);
    assign tx_o.push_data = bus_i.wr_data;
    assign tx_o.cnt_idx   = stream_idx_t'(rd_idx);
    assign rx_o.pop_en    = bus_i.rd_req & (rd_region == REG_RX);   // FIFO drops pop when empty
    assign rx_o.pop_idx   = stream_idx_t'(rd_idx);

    // Write side readiness and response
    always_comb begin
        bus_i.wr_ready = 1'b1;
        bus_i.wr_ok    = 1'b0;
        case (wr_region)
            REG_CONF: bus_i.wr_ok = 1'b1;
            REG_TX: begin
                bus_i.wr_ready = tx_o.push_ready;       // Stall on full FIFO
                bus_i.wr_ok    = 1'b1;
            end
            default: bus_i.wr_ok = 1'b0;                // Read-only or unmapped
        endcase
    end

    // Read side readiness, response and data
    always_comb begin
        bus_i.rd_ready = 1'b1;
        bus_i.rd_ok    = 1'b1;
        bus_i.rd_data  = '0;
        case (rd_region)
            REG_CONF: bus_i.rd_data = conf_reg_o[rd_idx];
            REG_STAT: bus_i.rd_data = stat_reg_i[rd_idx];
            REG_TX:   bus_i.rd_data = data_t'(tx_o.count);  // Occupancy, zero extended
            REG_RX: begin
                bus_i.rd_ready = rx_o.pop_ready;        // Stall on empty FIFO
                bus_i.rd_data  = rx_o.pop_data;
            end
            default: bus_i.rd_ok = 1'b0;
        endcase
    end

    // Configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conf_reg_o <= '{default: '0};
        end else if (bus_i.wr_req && bus_i.wr_ready && wr_region == REG_CONF) begin
            conf_reg_o[wr_idx] <= bus_i.wr_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/stream_fifo.sv
/* Synchronous byte FIFO with an occupancy count, used by both stream blocks.
   Push when full and pop when empty are dropped */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module stream_fifo #(
    parameter int DEPTH = `AXC_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push_i,
    input  axi_ctrl_pkg::data_t push_data_i,
    input  logic                pop_i,
    output axi_ctrl_pkg::data_t pop_data_o,
    output logic                full_o,
    output logic                empty_o,
    output axi_ctrl_pkg::cnt_t  count_o
);
    import axi_ctrl_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    data_t            mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             do_push;
    logic             do_pop;

    assign full_o     = (count_o == cnt_t'(DEPTH));
    assign empty_o    = (count_o == '0);
    assign do_push    = push_i & ~full_o;
    assign do_pop     = pop_i & ~empty_o;
    assign pop_data_o = mem_q[rd_ptr_q];    // Head, valid when not empty

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_o  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_o <= count_o + cnt_t'(do_push) - cnt_t'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/tx_stream.sv
/* Transmit streams. Bus writes push into the FIFO picked by index, the far side
   pops bytes out, and a bus read returns one FIFO's count */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module tx_stream (
    input  logic                    clk,
    input  logic                    rst_n,
    tx_port_if.slave                port_i,
    output axi_ctrl_pkg::data_t     tx_data_o [`AXC_TX_NUM],
    output logic [`AXC_TX_NUM-1:0]  tx_valid_o,
    input  logic [`AXC_TX_NUM-1:0]  tx_pop_i
);
    import axi_ctrl_pkg::*;

    logic [`AXC_TX_NUM-1:0] full;
    logic [`AXC_TX_NUM-1:0] empty;
    cnt_t                   count [`AXC_TX_NUM];

    for (genvar i = 0; i < `AXC_TX_NUM; i++) begin : g_fifo
        stream_fifo #(.DEPTH(`AXC_FIFO_DEPTH)) i_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (port_i.push_en && port_i.push_idx == stream_idx_t'(i)),
            .push_data_i (port_i.push_data),
            .pop_i       (tx_pop_i[i]),             // Far side read end
            .pop_data_o  (tx_data_o[i]),
            .full_o      (full[i]),
            .empty_o     (empty[i]),
            .count_o     (count[i])
        );
        assign tx_valid_o[i] = ~empty[i];
    end

    assign port_i.push_ready = ~full[port_i.push_idx];
    assign port_i.count      = count[port_i.cnt_idx];

endmodule

`default_nettype wire

// File: logic/rx_stream.sv
/* Receive streams. The far side pushes bytes in, a bus read pops the head of the
   FIFO picked by index */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module rx_stream (
    input  logic                    clk,
    input  logic                    rst_n,
    rx_port_if.slave                port_i,
    input  axi_ctrl_pkg::data_t     rx_data_i [`AXC_RX_NUM],
    input  logic [`AXC_RX_NUM-1:0]  rx_push_i,
    output logic [`AXC_RX_NUM-1:0]  rx_ready_o
);
    import axi_ctrl_pkg::*;

    logic [`AXC_RX_NUM-1:0] full;
    logic [`AXC_RX_NUM-1:0] empty;
    data_t                  head [`AXC_RX_NUM];

    for (genvar i = 0; i < `AXC_RX_NUM; i++) begin : g_fifo
        stream_fifo #(.DEPTH(`AXC_FIFO_DEPTH)) i_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (rx_push_i[i]),            // Far side write end
            .push_data_i (rx_data_i[i]),
            .pop_i       (port_i.pop_en && port_i.pop_idx == stream_idx_t'(i)),
            .pop_data_o  (head[i]),
            .full_o      (full[i]),
            .empty_o     (empty[i]),
            .count_o     ()
        );
        assign rx_ready_o[i] = ~full[i];
    end

    assign port_i.pop_ready = ~empty[port_i.pop_idx];
    assign port_i.pop_data  = head[port_i.pop_idx];

endmodule

`default_nettype wire

// File: logic/axi_ctrl_top.sv
/* Top level of the AXI peripheral controller. Plain AXI4-Lite slave ports, register
   and stream ports; wires the frontend, register map and stream blocks */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module axi_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // AXI4-Lite slave
    input  axi_ctrl_pkg::addr_t     s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  axi_ctrl_pkg::data_t     s_wdata_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output axi_ctrl_pkg::resp_e     s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  axi_ctrl_pkg::addr_t     s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output axi_ctrl_pkg::data_t     s_rdata_o,
    output axi_ctrl_pkg::resp_e     s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    // Registers
    input  axi_ctrl_pkg::data_t     stat_reg_i [`AXC_STAT_NUM],
    output axi_ctrl_pkg::data_t     conf_reg_o [`AXC_CONF_NUM],
    // Transmit streams
    output axi_ctrl_pkg::data_t     tx_data_o  [`AXC_TX_NUM],
    output logic [`AXC_TX_NUM-1:0]  tx_valid_o,
    input  logic [`AXC_TX_NUM-1:0]  tx_pop_i,
    // Receive streams
    input  axi_ctrl_pkg::data_t     rx_data_i  [`AXC_RX_NUM],
    input  logic [`AXC_RX_NUM-1:0]  rx_push_i,
    output logic [`AXC_RX_NUM-1:0]  rx_ready_o
);

    host_bus_if bus_if ();
    tx_port_if  tx_if ();
    rx_port_if  rx_if ();

    axi_lite_frontend i_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .bus_o       (bus_if.host)
    );

    reg_map i_reg_map (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_i      (bus_if.target),
        .stat_reg_i (stat_reg_i),
        .conf_reg_o (conf_reg_o),
        .tx_o       (tx_if.master),
        .rx_o       (rx_if.master)
    );

    tx_stream i_tx_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .port_i     (tx_if.slave),
        .tx_data_o  (tx_data_o),
        .tx_valid_o (tx_valid_o),
        .tx_pop_i   (tx_pop_i)
    );

    rx_stream i_rx_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .port_i     (rx_if.slave),
        .rx_data_i  (rx_data_i),
        .rx_push_i  (rx_push_i),
        .rx_ready_o (rx_ready_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_axi_ctrl.sv
/* Testbench for the AXI peripheral controller. Drives the AXI4-Lite slave and the
   stream ports, predicts every response with a reference model and checks B and R */
`timescale 1ns/1ps
`default_nettype none

`include "axi_ctrl_settings.svh"

module tb_axi_ctrl;
    import axi_ctrl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int NUM_TRANS  = 2 + 16 + 10 + 13 + 5 + 5;  // Bus transfers of all tests

    logic   clk = 1'b0;
    logic   rst_n;
    addr_t  awaddr;
    logic   awvalid;
    logic   awready;
    data_t  wdata;
    logic   wvalid;
    logic   wready;
    resp_e  bresp;
    logic   bvalid;
    logic   bready;
    addr_t  araddr;
    logic   arvalid;
    logic   arready;
    data_t  rdata;
    resp_e  rresp;
    logic   rvalid;
    logic   rready;
    data_t  stat_reg [`AXC_STAT_NUM];
    data_t  conf_reg [`AXC_CONF_NUM];
    data_t  tx_data  [`AXC_TX_NUM];
    logic [`AXC_TX_NUM-1:0] tx_valid;
    logic [`AXC_TX_NUM-1:0] tx_pop;
    data_t  rx_data  [`AXC_RX_NUM];
    logic [`AXC_RX_NUM-1:0] rx_push;
    logic [`AXC_RX_NUM-1:0] rx_ready;

    // Reference model state
    data_t  conf_m [`AXC_CONF_NUM];
    data_t  tx_q0 [$];
    data_t  tx_q1 [$];
    data_t  rx_q0 [$];
    data_t  rx_q1 [$];
    resp_e  exp_bresp_q [$];    // Filled at handshake, drained by compare process
    resp_e  exp_rresp_q [$];
    data_t  exp_rdata_q [$];

    int seed;
    int err_cnt = 0;
    int test_first_err = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    axi_ctrl_top i_dut (
        .clk (clk), .rst_n (rst_n),
        .s_awaddr_i (awaddr), .s_awvalid_i (awvalid), .s_awready_o (awready),
        .s_wdata_i (wdata), .s_wvalid_i (wvalid), .s_wready_o (wready),
        .s_bresp_o (bresp), .s_bvalid_o (bvalid), .s_bready_i (bready),
        .s_araddr_i (araddr), .s_arvalid_i (arvalid), .s_arready_o (arready),
        .s_rdata_o (rdata), .s_rresp_o (rresp), .s_rvalid_o (rvalid), .s_rready_i (rready),
        .stat_reg_i (stat_reg), .conf_reg_o (conf_reg),
        .tx_data_o (tx_data), .tx_valid_o (tx_valid), .tx_pop_i (tx_pop),
        .rx_data_i (rx_data), .rx_push_i (rx_push), .rx_ready_o (rx_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic bit in_region(input addr_t addr, input addr_t base, input int num);
        return (addr >= base) && (addr < base + addr_t'(num));
    endfunction

    // Expected response and read data from the decode rules and the model state
    function automatic resp_e ref_access(input addr_t addr, input bit is_wr,
                                         output data_t exp_data);
        resp_e resp;
        int    off;
        resp     = RESP_DECERR;                 // Unmapped or refused
        exp_data = '0;
        if (in_region(addr, `AXC_CONF_BASE, `AXC_CONF_NUM)) begin
            off  = int'(addr - `AXC_CONF_BASE);
            resp = RESP_OKAY;
            if (!is_wr) begin
                exp_data = conf_m[off];
            end
        end else if (in_region(addr, `AXC_STAT_BASE, `AXC_STAT_NUM) && !is_wr) begin
            off      = int'(addr - `AXC_STAT_BASE);
            resp     = RESP_OKAY;
            exp_data = stat_reg[off];
        end else if (in_region(addr, `AXC_TX_BASE, `AXC_TX_NUM)) begin
            resp = RESP_OKAY;
            if (!is_wr) begin
                exp_data = data_t'((addr == `AXC_TX_BASE) ? tx_q0.size() : tx_q1.size());
            end
        end else if (in_region(addr, `AXC_RX_BASE, `AXC_RX_NUM) && !is_wr) begin
            resp     = RESP_OKAY;
            exp_data = (addr == `AXC_RX_BASE) ? rx_q0[0] : rx_q1[0];   // Head byte
        end
        return resp;
    endfunction

    // Side effects of an accepted transfer
    task automatic update_model(input addr_t addr, input bit is_wr, input data_t wr_byte);
        if (is_wr && in_region(addr, `AXC_CONF_BASE, `AXC_CONF_NUM)) begin
            conf_m[int'(addr - `AXC_CONF_BASE)] = wr_byte;
        end else if (is_wr && addr == `AXC_TX_BASE) begin
            tx_q0.push_back(wr_byte);
        end else if (is_wr && addr == `AXC_TX_BASE + 1) begin
            tx_q1.push_back(wr_byte);
        end else if (!is_wr && addr == `AXC_RX_BASE) begin
            void'(rx_q0.pop_front());
        end else if (!is_wr && addr == `AXC_RX_BASE + 1) begin
            void'(rx_q1.pop_front());
        end
    endtask

    // Hold cycles keep bready low and re-offer the write
    task automatic write_access(input addr_t addr, input data_t data, input int hold);
        data_t unused;
        resp_e exp_resp;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        do begin
            @(posedge clk);
        end while (!awready);
        check_value("wready with awready", wready, 1);
        exp_resp = ref_access(addr, 1'b1, unused);
        exp_bresp_q.push_back(exp_resp);
        update_model(addr, 1'b1, data);
        @(negedge clk);
        check_value("bvalid one cycle after write handshake", bvalid, 1);
        repeat (hold) begin
            @(negedge clk);
            check_value("awready while B pending", awready, 0);
            check_value("wready while B pending", wready, 0);
            check_value("bvalid under back-pressure", bvalid, 1);
            check_value("bresp held", bresp, exp_resp);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do begin
            @(posedge clk);
        end while (!(bvalid && bready));
        @(negedge clk);                 // B beat already compared
    endtask

    task automatic read_access(input addr_t addr, input int hold);
        data_t exp_data;
        resp_e exp_resp;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        do begin
            @(posedge clk);
        end while (!arready);
        exp_resp = ref_access(addr, 1'b0, exp_data);
        exp_rresp_q.push_back(exp_resp);
        exp_rdata_q.push_back(exp_data);
        update_model(addr, 1'b0, '0);
        @(negedge clk);
        check_value("rvalid one cycle after read handshake", rvalid, 1);
        repeat (hold) begin
            @(negedge clk);
            check_value("arready while R pending", arready, 0);
            check_value("rvalid under back-pressure", rvalid, 1);
            check_value("rresp held", rresp, exp_resp);
            check_value("rdata held", rdata, exp_data);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        do begin
            @(posedge clk);
        end while (!(rvalid && rready));
        @(negedge clk);                 // R beat already compared
    endtask

    task automatic pop_tx(input int idx);
        data_t exp_byte;
        @(negedge clk);
        if (idx == 0) begin
            exp_byte = tx_q0.pop_front();
        end else begin
            exp_byte = tx_q1.pop_front();
        end
        check_value("tx_valid before pop", tx_valid[idx], 1);
        check_value("tx_data order", tx_data[idx], exp_byte);
        tx_pop[idx] = 1'b1;
        @(negedge clk);
        tx_pop[idx] = 1'b0;
    endtask

    task automatic push_rx(input int idx, input data_t rx_byte);
        @(negedge clk);
        check_value("rx_ready before push", rx_ready[idx], 1);
        rx_data[idx] = rx_byte;
        rx_push[idx] = 1'b1;
        if (idx == 0) begin
            rx_q0.push_back(rx_byte);
        end else begin
            rx_q1.push_back(rx_byte);
        end
        @(negedge clk);
        rx_push[idx] = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_cnt - test_first_err;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d errors", name, errs);
        end
        test_first_err = err_cnt;
    endtask

    // Compare process, one expected entry per B or R beat
    always @(posedge clk) begin
        if (bvalid && bready) begin
            if (exp_bresp_q.size() == 0) begin
                $display("Error at %0t: B response with no write outstanding", $time);
                err_cnt++;
            end else begin
                check_value("bresp", bresp, exp_bresp_q.pop_front());
            end
        end
        if (rvalid && rready) begin
            if (exp_rresp_q.size() == 0) begin
                $display("Error at %0t: R response with no read outstanding", $time);
                err_cnt++;
            end else begin
                check_value("rresp", rresp, exp_rresp_q.pop_front());
                check_value("rdata", rdata, exp_rdata_q.pop_front());
            end
        end
    end

    // Watchdog, 40 cycles per transfer plus reset
    initial begin
        #((NUM_TRANS * 40 + RST_CYCLES) * CLK_PERIOD);
        $display("Timeout at %0t: a handshake or response never arrived", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        data_t d;
        seed    = 32'hec55;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        tx_pop  = '0;
        rx_push = '0;
        rx_data = '{default: '0};
        conf_m  = '{default: '0};
        for (int i = 0; i < `AXC_STAT_NUM; i++) begin
            stat_reg[i] = data_t'($random(seed));
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_value("bvalid after reset", bvalid, 0);
        check_value("rvalid after reset", rvalid, 0);
        check_value("tx_valid after reset", tx_valid, 0);
        check_value("rx_ready after reset", rx_ready, {`AXC_RX_NUM{1'b1}});
        for (int i = 0; i < `AXC_CONF_NUM; i++) begin
            check_value("conf_reg after reset", conf_reg[i], 0);
        end
        read_access(`AXC_TX_BASE, 0);
        read_access(`AXC_TX_BASE + 1, 0);
        finish_test("reset values");

        for (int i = 0; i < `AXC_CONF_NUM; i++) begin
            d = data_t'($random(seed));
            write_access(`AXC_CONF_BASE + i, d, i % 3);
            check_value("conf_reg after write", conf_reg[i], d);
        end
        for (int i = 0; i < `AXC_CONF_NUM; i++) begin
            read_access(`AXC_CONF_BASE + i, i % 2);
        end
        finish_test("configuration region");

        for (int i = 0; i < `AXC_STAT_NUM; i++) begin
            read_access(`AXC_STAT_BASE + i, 0);
        end
        write_access(`AXC_STAT_BASE + 3, data_t'($random(seed)), 0);   // Read-only
        read_access(`AXC_STAT_BASE + 3, 0);
        finish_test("status region");

        for (int k = 0; k < `AXC_FIFO_DEPTH; k++) begin
            write_access(`AXC_TX_BASE, data_t'($random(seed)), k % 2);
            read_access(`AXC_TX_BASE, 0);                  // Count follows queue
        end
        fork
            write_access(`AXC_TX_BASE, data_t'($random(seed)), 0);
            begin
                @(negedge clk);
                repeat (5) begin
                    @(negedge clk);
                    check_value("awready on full TX FIFO", awready, 0);
                    check_value("wready on full TX FIFO", wready, 0);
                    check_value("bvalid on full TX FIFO", bvalid, 0);
                end
                pop_tx(0);                                  // Frees one slot
            end
        join
        read_access(`AXC_TX_BASE, 0);
        repeat (`AXC_FIFO_DEPTH) pop_tx(0);
        read_access(`AXC_TX_BASE, 0);
        write_access(`AXC_TX_BASE + 1, data_t'($random(seed)), 0);
        read_access(`AXC_TX_BASE + 1, 0);
        pop_tx(1);
        @(negedge clk);
        check_value("tx_valid after drain", tx_valid, 0);
        finish_test("transmit region");

        for (int i = 0; i < 3; i++) begin
            push_rx(0, data_t'($random(seed)));
        end
        for (int i = 0; i < 3; i++) begin
            read_access(`AXC_RX_BASE, i % 2);
        end
        fork
            read_access(`AXC_RX_BASE + 1, 0);
            begin
                @(negedge clk);
                repeat (5) begin
                    @(negedge clk);
                    check_value("arready on empty RX FIFO", arready, 0);
                    check_value("rvalid on empty RX FIFO", rvalid, 0);
                end
                push_rx(1, data_t'($random(seed)));
            end
        join
        write_access(`AXC_RX_BASE, data_t'($random(seed)), 0);   // Read-only
        finish_test("receive region");

        write_access(32'h2300_0000, data_t'($random(seed)), 0);
        read_access(`AXC_CONF_BASE + `AXC_CONF_NUM, 0);   // Just past the registers
        read_access(`AXC_RX_BASE + `AXC_RX_NUM, 0);
        d = data_t'($random(seed));
        write_access(`AXC_CONF_BASE + 1, d, 4);
        read_access(`AXC_CONF_BASE + 1, 4);
        check_value("conf_reg after held write", conf_reg[1], d);
        finish_test("unmapped and back-pressure");

        $display("Tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/axi_ctrl_pkg.sv
logic/axi_ctrl_if.sv
logic/axi_lite_frontend.sv
logic/reg_map.sv
logic/stream_fifo.sv
logic/tx_stream.sv
logic/rx_stream.sv
logic/axi_ctrl_top.sv
dv/tb_axi_ctrl.sv

// File: Bender.yml
package:
  name: axi_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/axi_ctrl_pkg.sv
      - logic/axi_ctrl_if.sv
      - logic/axi_lite_frontend.sv
      - logic/reg_map.sv
      - logic/stream_fifo.sv
      - logic/tx_stream.sv
      - logic/rx_stream.sv
      - logic/axi_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_axi_ctrl.sv
